/* Makefile */
VERILATOR ?= verilator
TOP       ?= arcade_rom_tb
FILELIST  ?= arcade_rom.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

SRCS := $(shell grep -v '^+' $(FILELIST)) arcade_rom_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* arcade_rom.f */
+incdir+.
arcade_rom_pkg.sv
rom_download_router.sv
rom_fetch_port.sv
rom_mem_arbiter.sv
arcade_rom_top.sv
arcade_rom_tb.sv

/* arcade_rom_defines.svh */
`ifndef ARCADE_ROM_DEFINES_SVH
`define ARCADE_ROM_DEFINES_SVH

// ==================================================
// Port and address layout
// ==================================================
`define NUM_PORTS       2        // 0 main CPU, 1 sound CPU
`define BYTE_AW         16       // Client and download byte address
`define WORD_AW         15       // Memory word address

// ==================================================
// Download regions and memory placement
// ==================================================
`define REGION1_BASE    16'h8000 // Sound region starts here
`define REGION1_END     16'hC000 // First byte past sound region
`define MEM_WORD_BASE1  15'h4000 // Word offset of sound region

// Cycles spent in one store access
`define MEM_LAT         3

`endif

/* arcade_rom_pkg.sv */
`default_nettype none

package arcade_rom_pkg;

	`include "arcade_rom_defines.svh"

	// ==================================================
	// Port request to the arbiter
	// ==================================================
	typedef struct packed {
		logic                we; // Write enable
		logic [1:0]          ds; // Lane enables, bit 1 is upper byte
		logic [`WORD_AW-1:0] a;  // Port-relative word address
		logic [15:0]         d;  // Write data
	} mem_req_t;

	// ==================================================
	// Host download byte
	// ==================================================
	typedef struct packed {
		logic                active; // Download in progress
		logic                wr;     // Strobe level, rising edge writes
		logic [`BYTE_AW-1:0] addr;
		logic [7:0]          data;
	} dl_t;

	// Arbiter sequencing
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ACCESS,
		ARB_DONE
	} arb_state_e;

endpackage

`default_nettype wire

/* arcade_rom_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arcade_rom_defines.svh"

module arcade_rom_tb;
	import arcade_rom_pkg::*;

	localparam int IMG_BYTES = `REGION1_END;        // Both regions back to back
	localparam int DL_GAP    = 12;                  // Cycles between download writes
	localparam int ACC_TMO   = 4 * (`MEM_LAT + 4);
	localparam int N_ENTRIES = 14;

	typedef struct packed {
		logic [1:0]          port; // 2 drives both ports at once
		logic [`BYTE_AW-1:0] addr; // Port-relative byte address
		logic                rep;  // Same word as the previous read
	} rd_entry_t;

	localparam rd_entry_t RD_TABLE [N_ENTRIES] = '{
		{2'd0, 16'h0000, 1'b0}, {2'd0, 16'h0001, 1'b1}, {2'd0, 16'h1235, 1'b0},
		{2'd0, 16'h1234, 1'b1}, {2'd0, 16'h7fff, 1'b0}, {2'd1, 16'h0000, 1'b0},
		{2'd1, 16'h0001, 1'b1}, {2'd1, 16'h2a47, 1'b0}, {2'd1, 16'h3ffe, 1'b0},
		{2'd1, 16'h3fff, 1'b1}, {2'd2, 16'h0456, 1'b0}, {2'd2, 16'h3001, 1'b0},
		{2'd2, 16'h3000, 1'b1}, {2'd0, 16'h5679, 1'b0}
	};

	logic                  clk_sys;
	logic                  rst_n;
	dl_t                   dl;
	logic                  reset_req;
	logic [`BYTE_AW-1:0]   rd_addr [`NUM_PORTS];
	logic [`NUM_PORTS-1:0] rd;
	wire  [7:0]            rd_data [`NUM_PORTS];
	wire  [`NUM_PORTS-1:0] rd_busy;
	wire                   game_reset;

	logic [7:0]            image [IMG_BYTES];
	logic [31:0]           lfsr;

	arcade_rom_top i_arcade_rom_top (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl),
		.reset_req  (reset_req),
		.rd_addr    (rd_addr),
		.rd         (rd),
		.rd_data    (rd_data),
		.rd_busy    (rd_busy),
		.game_reset (game_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	// ==================================================
	// Helpers
	// ==================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] expected_byte(input int port, input logic [15:0] addr);
		if (port == 0)
			return image[int'(addr)];
		else
			return image[int'(`REGION1_BASE) + int'(addr)]; // Sound region follows main
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s, got 'h%0h, expected 'h%0h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// Called on a falling edge, polls on falling edges
	task automatic poll_busy(input logic [1:0] mask, input logic high,
	                         input int max_cycles, input string what);
		int   n;
		logic done;
		n    = 0;
		done = 1'b0;
		while (!done) begin
			if (high ? ((rd_busy & mask) == mask) : ((rd_busy & mask) == 2'b00))
				done = 1'b1;
			else if (n >= max_cycles)
				stop_on_timeout(what);
			else begin
				@(negedge clk_sys);
				n++;
			end
		end
	endtask

	task automatic follow_game_reset(input logic level, input int max_cycles,
	                                 input string what);
		int n;
		n = 0;
		while (game_reset !== level) begin
			if (n >= max_cycles)
				stop_on_timeout(what);
			else begin
				@(negedge clk_sys);
				n++;
			end
		end
	endtask

	task automatic fill_image();
		logic [7:0] b;
		lfsr = 32'hdad298f5;
		for (int i = 0; i < IMG_BYTES; i++) begin
			b = '0;
			for (int k = 0; k < 8; k++) begin
				lfsr = lfsr_step(lfsr); // One step per bit
				b    = {b[6:0], lfsr[0]};
			end
			image[i] = b;
		end
	endtask

	task automatic stream_image();
		@(posedge clk_sys);
		dl.active <= 1'b1;
		for (int i = 0; i < IMG_BYTES; i++) begin
			@(posedge clk_sys);
			dl.addr <= `BYTE_AW'(i);
			dl.data <= image[i];
			dl.wr   <= 1'b1;
			@(posedge clk_sys);
			dl.wr   <= 1'b0;
			@(negedge clk_sys);
			check_value("game_reset during download", game_reset, 1'b1);
			repeat (DL_GAP - 2) @(posedge clk_sys);
		end
		@(posedge clk_sys);
		dl.active <= 1'b0;
	endtask

	task automatic apply_entry(input rd_entry_t e);
		logic [1:0] mask;
		mask = (e.port == 2'd2) ? 2'b11 : (2'b01 << e.port);
		@(posedge clk_sys);
		for (int p = 0; p < `NUM_PORTS; p++) begin
			if (mask[p]) begin
				rd_addr[p] <= e.addr;
				rd[p]      <= 1'b1;
			end
		end
		@(negedge clk_sys);
		if (e.rep) begin
			// Unchanged word, no fetch expected
			repeat (`MEM_LAT + 3) begin
				check_value("rd_busy on unchanged word", rd_busy & mask, 2'b00);
				@(negedge clk_sys);
			end
		end else begin
			poll_busy(mask, 1'b1, 3, "rd_busy to rise");
			poll_busy(mask, 1'b0, ACC_TMO, "rd_busy to fall");
		end
		for (int p = 0; p < `NUM_PORTS; p++) begin
			if (mask[p])
				check_value($sformatf("port %0d byte at 'h%0h", p, e.addr),
				            rd_data[p], expected_byte(p, e.addr));
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		rst_n     = 1'b0;
		dl        = '0;
		reset_req = 1'b0;
		rd        = '0;
		for (int p = 0; p < `NUM_PORTS; p++)
			rd_addr[p] = '0;
		fill_image();
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_value("game_reset after reset", game_reset, 1'b1);

		stream_image();
		@(negedge clk_sys);
		follow_game_reset(1'b0, 6, "game_reset release after download");

		for (int i = 0; i < N_ENTRIES; i++)
			apply_entry(RD_TABLE[i]);

		// External reset request, image stays loaded
		@(posedge clk_sys);
		reset_req <= 1'b1;
		@(negedge clk_sys);
		follow_game_reset(1'b1, 4, "game_reset on reset_req");
		@(posedge clk_sys);
		reset_req <= 1'b0;
		@(negedge clk_sys);
		follow_game_reset(1'b0, 4, "game_reset release after reset_req");
		apply_entry(RD_TABLE[2]);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* arcade_rom_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arcade_rom_defines.svh"

module arcade_rom_top (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  wire arcade_rom_pkg::dl_t dl,
	input  wire                      reset_req,
	input  wire [`BYTE_AW-1:0]       rd_addr [`NUM_PORTS],
	input  wire [`NUM_PORTS-1:0]     rd,
	output wire [7:0]                rd_data [`NUM_PORTS],
	output wire [`NUM_PORTS-1:0]     rd_busy,
	output wire                      game_reset
);
	import arcade_rom_pkg::*;

	wire [`NUM_PORTS-1:0] wr_stb;
	wire mem_req_t        wr_req;
	wire                  downloading;
	wire mem_req_t        req [`NUM_PORTS];
	wire [`NUM_PORTS-1:0] req_tgl;
	wire [`NUM_PORTS-1:0] ack_tgl;
	wire [15:0]           q; // Shared by all ports

	rom_download_router i_rom_download_router (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl),
		.reset_req   (reset_req),
		.wr_stb      (wr_stb),
		.wr_req      (wr_req),
		.downloading (downloading),
		.game_reset  (game_reset)
	);

	// Port 0 main CPU, port 1 sound CPU
	for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
		rom_fetch_port i_rom_fetch_port (
			.clk_sys     (clk_sys),
			.rst_n       (rst_n),
			.downloading (downloading),
			.wr_stb      (wr_stb[p]),
			.wr_req      (wr_req),
			.rd          (rd[p]),
			.rd_addr     (rd_addr[p]),
			.ack_tgl     (ack_tgl[p]),
			.q           (q),
			.req         (req[p]),
			.req_tgl     (req_tgl[p]),
			.rd_data     (rd_data[p]),
			.rd_busy     (rd_busy[p])
		);
	end

	rom_mem_arbiter i_rom_mem_arbiter (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.req     (req),
		.req_tgl (req_tgl),
		.ack_tgl (ack_tgl),
		.q       (q)
	);

endmodule

`default_nettype wire

/* rom_download_router.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arcade_rom_defines.svh"

module rom_download_router (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  wire arcade_rom_pkg::dl_t dl,
	input  wire                      reset_req,
	output logic [`NUM_PORTS-1:0]    wr_stb,
	output arcade_rom_pkg::mem_req_t wr_req,
	output logic                     downloading,
	output logic                     game_reset
);
	import arcade_rom_pkg::*;

	logic                wr_d1;
	logic                wr_d2;
	logic [`BYTE_AW-1:0] addr_d1;
	logic [7:0]          data_d1;
	logic                wr_rise;
	logic                in_rgn0;
	logic                in_rgn1;
	logic [`WORD_AW-1:0] rel_wa;
	logic                rom_loaded;
	mem_req_t            req_nxt;

	// ==================================================
	// Strobe edge detect and region decode
	// ==================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_d1 <= 1'b0;
			wr_d2 <= 1'b0;
		end else begin
			wr_d1 <= dl.wr;
			wr_d2 <= wr_d1;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_d1 <= dl.addr; // Sampled with the strobe
		data_d1 <= dl.data;
	end

	assign wr_rise = wr_d1 & ~wr_d2;
	assign in_rgn0 = addr_d1 < `REGION1_BASE;
	assign in_rgn1 = (addr_d1 >= `REGION1_BASE) && (addr_d1 < `REGION1_END);

	// Word address relative to the start of its region
	assign rel_wa = in_rgn1 ? addr_d1[`BYTE_AW-1:1] - `WORD_AW'(`REGION1_BASE >> 1)
	                        : addr_d1[`BYTE_AW-1:1];

	always_comb begin
		req_nxt.we = 1'b1;
		req_nxt.ds = {addr_d1[0], ~addr_d1[0]}; // Odd byte goes to upper lane
		req_nxt.a  = rel_wa;
		req_nxt.d  = {data_d1, data_d1};
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_stb <= '0;
		end else begin
			wr_stb    <= '0;
			wr_stb[0] <= wr_rise & in_rgn0; // Main CPU region
			wr_stb[1] <= wr_rise & in_rgn1; // Sound CPU region
		end
	end

	always_ff @(posedge clk_sys) begin
		wr_req <= req_nxt;
	end

	// ==================================================
	// Load tracking and game reset
	// ==================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			downloading <= 1'b0;
			rom_loaded  <= 1'b0;
			game_reset  <= 1'b1;
		end else begin
			downloading <= dl.active;
			if (downloading && !dl.active)
				rom_loaded <= 1'b1; // Falling edge of the download
			game_reset <= reset_req | ~rom_loaded;
		end
	end

	// Host stays inside the two regions
	a_addr_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(dl.wr) |-> dl.addr < `REGION1_END);

endmodule

`default_nettype wire

/* rom_fetch_port.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arcade_rom_defines.svh"

module rom_fetch_port (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire                           downloading,
	input  wire                           wr_stb,
	input  wire arcade_rom_pkg::mem_req_t wr_req,
	input  wire                           rd,
	input  wire [`BYTE_AW-1:0]            rd_addr,
	input  wire                           ack_tgl,
	input  wire [15:0]                    q,
	output arcade_rom_pkg::mem_req_t      req,
	output logic                          req_tgl,
	output logic [7:0]                    rd_data,
	output logic                          rd_busy
);
	import arcade_rom_pkg::*;

	// Extra top bit marks an address no client can present
	localparam logic [`WORD_AW:0] NO_ADDR = {1'b1, {`WORD_AW{1'b0}}};

	logic                pending;
	logic                ack_seen;
	logic                ack_new;
	logic [`WORD_AW:0]   last_wa;
	logic [`WORD_AW:0]   rd_wa;
	logic                issue_rd;
	logic [15:0]         word_q;
	logic [15:0]         word_sel;
	mem_req_t            rd_req;

	assign pending = req_tgl ^ ack_tgl;
	assign ack_new = ack_tgl ^ ack_seen; // High in the cycle after the arbiter answers
	assign rd_wa   = {1'b0, rd_addr[`BYTE_AW-1:1]};

	// Reads only outside a download and only on a new word
	assign issue_rd = !downloading && rd && !pending && !wr_stb && (last_wa != rd_wa);

	always_comb begin
		rd_req.we = 1'b0;
		rd_req.ds = 2'b11;
		rd_req.a  = rd_addr[`BYTE_AW-1:1];
		rd_req.d  = '0;
	end

	// ==================================================
	// Request toggle
	// ==================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			req_tgl  <= 1'b0;
			ack_seen <= 1'b0;
			last_wa  <= NO_ADDR;
		end else begin
			ack_seen <= ack_tgl;
			if (downloading)
				last_wa <= NO_ADDR; // First read afterwards always fetches
			if (wr_stb) begin
				req_tgl <= ~req_tgl;
			end else if (issue_rd) begin
				last_wa <= rd_wa;
				req_tgl <= ~req_tgl;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_stb)
			req <= wr_req;
		else if (issue_rd)
			req <= rd_req;
		if (ack_new && !req.we)
			word_q <= q; // Keep the word once q moves on
	end

	// ==================================================
	// Read data
	// ==================================================
	// Fresh word comes straight from q in the acknowledge cycle
	assign word_sel = (ack_new && !req.we) ? q : word_q;
	assign rd_data  = rd_addr[0] ? word_sel[15:8] : word_sel[7:0];
	assign rd_busy  = pending;

	// Download writes must be spaced beyond the arbiter turnaround
	a_wr_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_stb |-> !pending);

endmodule

`default_nettype wire

/* rom_mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arcade_rom_defines.svh"

module rom_mem_arbiter (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire arcade_rom_pkg::mem_req_t req [`NUM_PORTS],
	input  wire [`NUM_PORTS-1:0]          req_tgl,
	output logic [`NUM_PORTS-1:0]         ack_tgl,
	output logic [15:0]                   q
);
	import arcade_rom_pkg::*;

	localparam int PW = $clog2(`NUM_PORTS);
	localparam int CW = $clog2(`MEM_LAT + 1);

	// Region word base per port
	localparam logic [`WORD_AW-1:0] PORT_BASE [`NUM_PORTS] = '{'0, `MEM_WORD_BASE1};

	arb_state_e          state;
	logic [PW-1:0]       cur_port;
	logic [PW-1:0]       last_port;
	logic [CW-1:0]       cnt;
	logic [`WORD_AW-1:0] mem_a;
	logic [`NUM_PORTS-1:0] pend;
	logic                pick_vld;
	logic [PW-1:0]       pick;
	logic [15:0]         mem [2**`WORD_AW]; // Stand-in for the SDRAM

	assign pend = req_tgl ^ ack_tgl;

	// Round-robin from the nearest pending port after the last one served
	always_comb begin
		pick_vld = 1'b0;
		pick     = last_port;
		for (int i = `NUM_PORTS; i >= 1; i--) begin
			if (pend[(int'(last_port) + i) % `NUM_PORTS]) begin
				pick_vld = 1'b1;
				pick     = PW'((int'(last_port) + i) % `NUM_PORTS);
			end
		end
	end

	// ==================================================
	// Access FSM
	// ==================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ARB_IDLE;
			cur_port  <= '0;
			last_port <= '0;
			cnt       <= '0;
			ack_tgl   <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_vld) begin
						cur_port <= pick;
						cnt      <= CW'(`MEM_LAT - 1);
						state    <= ARB_ACCESS;
					end
				end
				ARB_ACCESS: begin
					if (cnt == '0)
						state <= ARB_DONE;
					else
						cnt <= cnt - 1'b1;
				end
				ARB_DONE: begin
					ack_tgl[cur_port] <= ~ack_tgl[cur_port]; // Same edge as q
					last_port         <= cur_port;
					state             <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Absolute word address latched at grant
	always_ff @(posedge clk_sys) begin
		if (state == ARB_IDLE && pick_vld)
			mem_a <= req[pick].a + PORT_BASE[pick];
	end

	// ==================================================
	// Word store
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (state == ARB_DONE) begin
			if (req[cur_port].we) begin
				if (req[cur_port].ds[0])
					mem[mem_a][7:0] <= req[cur_port].d[7:0];
				if (req[cur_port].ds[1])
					mem[mem_a][15:8] <= req[cur_port].d[15:8];
			end else begin
				q <= mem[mem_a];
			end
		end
	end

	// Served request stays pending for the whole access
	a_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(state != ARB_IDLE) |-> pend[cur_port]);

endmodule

`default_nettype wire
